/* logic/ialu_pkg.sv */
// --------------------
// Shared types of the integer ALU: word width, command codes,
// request, adder flags and multiplier kind
// --------------------

`default_nettype none

package ialu_pkg;

    // --------------------
    // Data word
    // --------------------
    localparam int ialu_xlen = 32;                 // Operand and result width

    typedef logic [ialu_xlen-1:0] ialu_word_t;

    // --------------------
    // Operation codes
    // --------------------
    typedef enum logic [4:0] {
        cmd_add    = 5'd0,
        cmd_sub    = 5'd1,
        cmd_lt     = 5'd2,                         // Signed less than
        cmd_ltu    = 5'd3,                         // Unsigned less than
        cmd_eq     = 5'd4,
        cmd_ne     = 5'd5,
        cmd_ge     = 5'd6,
        cmd_geu    = 5'd7,
        cmd_and    = 5'd8,
        cmd_or     = 5'd9,
        cmd_xor    = 5'd10,
        cmd_sll    = 5'd11,
        cmd_srl    = 5'd12,
        cmd_sra    = 5'd13,
        cmd_mul    = 5'd14,                        // Low word of product
        cmd_mulh   = 5'd15,                        // High word, signed x signed
        cmd_mulhsu = 5'd16,                        // High word, signed x unsigned
        cmd_mulhu  = 5'd17                         // High word, unsigned x unsigned
    } ialu_cmd_e;

    // --------------------
    // Request and status bundles
    // --------------------
    typedef struct packed {
        ialu_cmd_e  cmd;
        ialu_word_t op1;
        ialu_word_t op2;
    } ialu_req_s;

    // Flags of the main adder, taken from the 33-bit result
    typedef struct packed {
        logic zero;
        logic sign;
        logic overflow;
        logic carry;                               // Borrow on subtract
    } ialu_flags_s;

    typedef struct packed {
        logic op1_signed;
        logic op2_signed;                          // Top multiplier bit weighs negative
        logic high_half;                           // Return upper product word
    } ialu_mul_kind_s;

endpackage

`default_nettype wire

/* logic/ialu_adder_cmp.sv */
// --------------------
// Main adder/subtractor of the ALU with zero, sign,
// overflow and carry flags for the compares
// --------------------

`timescale 1ns/10ps
`default_nettype none

module ialu_adder_cmp
    import ialu_pkg::*;
(
    input  ialu_word_t  op1,
    input  ialu_word_t  op2,
    input  logic        sub,                       // 0 add, 1 subtract
    output ialu_word_t  sum,
    output ialu_flags_s flags
);

    // --------------------
    // Local signals
    // --------------------
    logic [ialu_xlen:0] res_ext;                   // Result with carry-out
    logic               op1_msb;
    logic               op2_msb;
    logic               res_msb;

    // --------------------
    // Adder
    // --------------------
    always_comb begin
        if (sub) begin
            res_ext = {1'b0, op1} - {1'b0, op2};   // Carry bit is the borrow
        end else begin
            res_ext = {1'b0, op1} + {1'b0, op2};
        end
    end

    assign sum = res_ext[ialu_xlen-1:0];

    // --------------------
    // Flags
    // --------------------
    assign op1_msb = op1[ialu_xlen-1];
    assign op2_msb = op2[ialu_xlen-1];
    assign res_msb = res_ext[ialu_xlen-1];

    always_comb begin
        flags.zero     = ~|res_ext[ialu_xlen-1:0];
        flags.sign     = res_msb;
        flags.carry    = res_ext[ialu_xlen];
        // Signs of the operands differ and the result left the sign of op1
        flags.overflow = (op1_msb ^ op2_msb) & (res_msb ^ op1_msb);
    end

endmodule

`default_nettype wire

/* logic/ialu_logic_shift.sv */
// --------------------
// Bitwise and/or/xor and barrel shifter of the ALU
// --------------------

`timescale 1ns/10ps
`default_nettype none

module ialu_logic_shift
    import ialu_pkg::*;
(
    input  ialu_cmd_e  cmd,
    input  ialu_word_t op1,
    input  ialu_word_t op2,
    output ialu_word_t res
);

    // --------------------
    // Local signals
    // --------------------
    logic [4:0] shamt;                             // Shift amount
    ialu_word_t sll_res;
    ialu_word_t srl_res;
    ialu_word_t sra_res;

    assign shamt = op2[4:0];

    // --------------------
    // Shifter
    // --------------------
    assign sll_res = op1 << shamt;
    assign srl_res = op1 >> shamt;
    assign sra_res = ialu_word_t'($signed(op1) >>> shamt);   // Sign fill from op1

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        case (cmd)
            cmd_and: res = op1 & op2;
            cmd_or:  res = op1 | op2;
            cmd_xor: res = op1 ^ op2;
            cmd_sll: res = sll_res;
            cmd_srl: res = srl_res;
            cmd_sra: res = sra_res;
            default: res = '0;                     // Not a logic or shift command
        endcase
    end

endmodule

`default_nettype wire

/* logic/ialu_mul_iter.sv */
// --------------------
// Iterative shift-and-add multiplier, mul_step multiplier
// bits per cycle, with its own step counter
// --------------------

`timescale 1ns/10ps
`default_nettype none

module ialu_mul_iter
    import ialu_pkg::*;
#(
    parameter int mul_step = 1                     // Multiplier bits per cycle, 1, 2 or 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,                  // First step, operands taken from inputs
    input  logic           step,                   // Following steps, from registers
    input  ialu_mul_kind_s kind,
    input  ialu_word_t     op1,
    input  ialu_word_t     op2,
    output logic           done,
    output ialu_word_t     prod_lo,
    output ialu_word_t     prod_hi
);

    // --------------------
    // Local parameters
    // --------------------
    localparam int n_steps = ialu_xlen / mul_step;
    localparam int cnt_w   = $clog2(n_steps) + 1;
    localparam int acc_w   = ialu_xlen + mul_step + 2;

    // --------------------
    // Local signals
    // --------------------
    logic [cnt_w-1:0]        cnt_q;                // Steps already taken
    ialu_word_t              hi_q;                 // Partial product, upper word
    ialu_word_t              lo_q;                 // Product low bits and remaining multiplier
    ialu_word_t              hi_cur;
    ialu_word_t              lo_cur;
    logic                    last;
    logic                    hi_signed;
    logic signed [ialu_xlen:0] mcand;              // op1 with one extension bit
    logic signed [mul_step:0]  digit;              // Multiplier bits of this step
    logic signed [acc_w-1:0]   hi_ext;
    logic signed [acc_w-1:0]   pp;
    logic signed [acc_w-1:0]   acc;

    // --------------------
    // Step datapath
    // --------------------
    always_comb begin
        hi_cur    = start ? '0 : hi_q;
        lo_cur    = start ? op2 : lo_q;
        last      = step & (cnt_q == cnt_w'(n_steps - 1));
        hi_signed = kind.op1_signed | kind.op2_signed;

        mcand = {kind.op1_signed & op1[ialu_xlen-1], op1};
        // On the last step the top bit of a signed op2 counts negative
        digit = {kind.op2_signed & last & lo_cur[mul_step-1], lo_cur[mul_step-1:0]};

        hi_ext = {{(mul_step + 2){hi_signed & hi_cur[ialu_xlen-1]}}, hi_cur};
        pp     = mcand * digit;
        acc    = hi_ext + pp;

        prod_hi = acc[ialu_xlen+mul_step-1:mul_step];
        prod_lo = {acc[mul_step-1:0], lo_cur[ialu_xlen-1:mul_step]};   // Shift right into low word
    end

    assign done = last;

    // --------------------
    // Step counter
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (start) begin
            cnt_q <= cnt_w'(1);
        end else if (step) begin
            cnt_q <= cnt_q + cnt_w'(1);
        end
    end

    // --------------------
    // Partial product registers
    // --------------------
    always_ff @(posedge clk) begin
        if (start | step) begin
            hi_q <= prod_hi;
            lo_q <= prod_lo;
        end
    end

endmodule

`default_nettype wire

/* logic/ialu_ctrl.sv */
// --------------------
// ALU control: command decode, idle/iterate FSM,
// ready/busy and final result select
// --------------------

`timescale 1ns/10ps
`default_nettype none

module ialu_ctrl
    import ialu_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           vd,
    input  ialu_cmd_e      cmd,
    input  ialu_word_t     op1,
    input  ialu_word_t     op2,
    input  ialu_word_t     sum,
    input  ialu_flags_s    flags,
    input  ialu_word_t     ls_res,
    input  logic           mul_done,
    input  ialu_word_t     prod_lo,
    input  ialu_word_t     prod_hi,
    output logic           sub,
    output logic           mul_start,
    output logic           mul_step,
    output ialu_mul_kind_s mul_kind,
    output logic           rdy,
    output logic           busy,
    output ialu_word_t     res,
    output logic           cmp
);

    typedef enum logic {
        st_idle,
        st_iter
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_nxt;
    logic        is_mul;
    logic        ops_nonzero;                      // Both operands nonzero
    logic        lt;
    logic        ltu;

    // --------------------
    // Decode
    // --------------------
    assign sub    = (cmd != cmd_add);
    assign is_mul = (cmd == cmd_mul) | (cmd == cmd_mulh) |
                    (cmd == cmd_mulhsu) | (cmd == cmd_mulhu);

    assign mul_kind.op1_signed = (cmd == cmd_mul) | (cmd == cmd_mulh) | (cmd == cmd_mulhsu);
    assign mul_kind.op2_signed = (cmd == cmd_mul) | (cmd == cmd_mulh);
    assign mul_kind.high_half  = (cmd != cmd_mul);

    assign ops_nonzero = (|op1) & (|op2);
    assign mul_start   = vd & is_mul & (state_q == st_idle) & ops_nonzero;
    assign mul_step    = vd & is_mul & (state_q == st_iter);

    // --------------------
    // FSM
    // --------------------
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            st_idle: if (mul_start) state_nxt = st_iter;
            st_iter: if (mul_done)  state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else if (!vd) begin
            state_q <= st_idle;                    // Abort on dropped request
        end else begin
            state_q <= state_nxt;
        end
    end

    // --------------------
    // Result forming
    // --------------------
    assign lt  = flags.sign ^ flags.overflow;
    assign ltu = flags.carry;

    always_comb begin
        res = '0;
        cmp = 1'b0;
        rdy = vd;
        case (cmd)
            cmd_add, cmd_sub: res = sum;
            cmd_lt:           cmp = lt;
            cmd_ltu:          cmp = ltu;
            cmd_eq:           cmp = flags.zero;
            cmd_ne:           cmp = ~flags.zero;
            cmd_ge:           cmp = ~lt;
            cmd_geu:          cmp = ~ltu;
            cmd_mul, cmd_mulh, cmd_mulhsu, cmd_mulhu: begin
                if (state_q == st_idle) begin
                    rdy = vd & ~ops_nonzero;       // Zero operand finishes at once
                end else begin
                    rdy = vd & mul_done;
                    res = mul_kind.high_half ? prod_hi : prod_lo;
                end
            end
            default:          res = ls_res;
        endcase
        if ((cmd >= cmd_lt) && (cmd <= cmd_geu)) begin
            res = ialu_word_t'(cmp);               // 0/1 compare word
        end
    end

    assign busy = vd & ~rdy;

endmodule

`default_nettype wire

/* logic/ialu_top.sv */
// --------------------
// Integer ALU top level: control, adder, logic/shift
// block and iterative multiplier
// --------------------

`timescale 1ns/10ps
`default_nettype none

module ialu_top
    import ialu_pkg::*;
#(
    parameter int mul_step = 1                     // Multiplier bits per cycle
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vd,
    input  ialu_req_s  req,
    output logic       rdy,
    output logic       busy,
    output ialu_word_t res,
    output logic       cmp
);

    // --------------------
    // Internal wires
    // --------------------
    logic           sub;
    ialu_word_t     sum;
    ialu_flags_s    flags;
    ialu_word_t     ls_res;
    logic           mul_start;
    logic           mul_step_en;
    ialu_mul_kind_s mul_kind;
    logic           mul_done;
    ialu_word_t     prod_lo;
    ialu_word_t     prod_hi;

    ialu_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .vd        (vd),
        .cmd       (req.cmd),
        .op1       (req.op1),
        .op2       (req.op2),
        .sum       (sum),
        .flags     (flags),
        .ls_res    (ls_res),
        .mul_done  (mul_done),
        .prod_lo   (prod_lo),
        .prod_hi   (prod_hi),
        .sub       (sub),
        .mul_start (mul_start),
        .mul_step  (mul_step_en),
        .mul_kind  (mul_kind),
        .rdy       (rdy),
        .busy      (busy),
        .res       (res),
        .cmp       (cmp)
    );

    ialu_adder_cmp u_adder_cmp (
        .op1   (req.op1),
        .op2   (req.op2),
        .sub   (sub),
        .sum   (sum),
        .flags (flags)
    );

    ialu_logic_shift u_logic_shift (
        .cmd (req.cmd),
        .op1 (req.op1),
        .op2 (req.op2),
        .res (ls_res)
    );

    ialu_mul_iter #(
        .mul_step (mul_step)
    ) u_mul_iter (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .step    (mul_step_en),
        .kind    (mul_kind),
        .op1     (req.op1),
        .op2     (req.op2),
        .done    (mul_done),
        .prod_lo (prod_lo),
        .prod_hi (prod_hi)
    );

endmodule

`default_nettype wire

/* verif/ialu_checker.sv */
// --------------------
// ALU checker: compares res and cmp at ready, checks busy,
// rdy latency and counts errors
// --------------------

`timescale 1ns/10ps
`default_nettype none

module ialu_checker
    import ialu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vd,
    input  logic       rdy,
    input  logic       busy,
    input  ialu_word_t res,
    input  logic       cmp,
    input  ialu_word_t exp_res,
    input  logic       exp_cmp,
    input  int         exp_lat,                    // Cycle of vd in which rdy is due
    output int         err_cnt,
    output int         chk_cnt
);

    logic op_open;                                 // Operation in flight
    int   cyc;                                     // Cycle count of the current operation
    logic exp_busy;                                // Request waiting, rdy not yet due

    always @(posedge clk) begin
        if (!rst_n) begin
            op_open = 1'b0;
            cyc     = 0;
            err_cnt = 0;
            chk_cnt = 0;
        end else begin
            if (vd !== 1'b1) begin
                if (rdy !== 1'b0) begin
                    $display("[ERROR] %0t rdy: got 0x%h, expected 0x0", $time, rdy);
                    err_cnt = err_cnt + 1;
                end
                if (busy !== 1'b0) begin
                    $display("[ERROR] %0t busy: got 0x%h, expected 0x0", $time, busy);
                    err_cnt = err_cnt + 1;
                end
                op_open = 1'b0;
            end else begin
                cyc      = op_open ? cyc + 1 : 1;
                exp_busy = (cyc < exp_lat);
                if (busy !== exp_busy) begin
                    $display("[ERROR] %0t busy: got 0x%h, expected 0x%h",
                             $time, busy, exp_busy);
                    err_cnt = err_cnt + 1;
                end
                if (rdy === 1'b1) begin
                    chk_cnt = chk_cnt + 1;
                    if (res !== exp_res) begin
                        $display("[ERROR] %0t res: got 0x%08h, expected 0x%08h",
                                 $time, res, exp_res);
                        err_cnt = err_cnt + 1;
                    end
                    if (cmp !== exp_cmp) begin
                        $display("[ERROR] %0t cmp: got 0x%h, expected 0x%h", $time, cmp, exp_cmp);
                        err_cnt = err_cnt + 1;
                    end
                    if (cyc != exp_lat) begin
                        $display("%0t rdy came in cycle %0d of the operation, not in cycle %0d",
                                 $time, cyc, exp_lat);
                        err_cnt = err_cnt + 1;
                    end
                    op_open = 1'b0;
                end else begin
                    if (cyc == exp_lat) begin
                        $display("%0t rdy is still low in cycle %0d of the operation",
                                 $time, cyc);
                        err_cnt = err_cnt + 1;
                    end
                    op_open = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_ialu.sv */
// --------------------
// ALU testbench: clock, reset, stimulus table with expected
// values, driver loop and watchdog
// --------------------

`timescale 1ns/10ps
`default_nettype none

module tb_ialu
    import ialu_pkg::*;
();

    localparam int mul_step       = 1;
    localparam int n_fixed        = 18 * 25 + 3;   // Corner pairs for every command, shift 31
    localparam int n_rows         = n_fixed + 60;
    localparam int rand_seed      = 7969;
    localparam int timeout_cycles = n_rows * (ialu_xlen + 4) + 16;

    typedef struct packed {
        ialu_cmd_e  cmd;
        ialu_word_t op1;
        ialu_word_t op2;
        ialu_word_t exp_res;
        logic       exp_cmp;
        int         lat;                           // Cycle of vd with rdy high
    } row_s;

    logic       clk;
    logic       rst_n;
    logic       vd;
    ialu_req_s  req;
    logic       rdy;
    logic       busy;
    ialu_word_t res;
    logic       cmp;
    ialu_word_t exp_res;
    logic       exp_cmp;
    int         exp_lat;
    int         err_cnt;
    int         chk_cnt;
    row_s       tbl [n_rows];

    ialu_top #(.mul_step(mul_step)) u_ialu_top (
        .clk(clk), .rst_n(rst_n), .vd(vd), .req(req),
        .rdy(rdy), .busy(busy), .res(res), .cmp(cmp)
    );

    ialu_checker u_checker (
        .clk(clk), .rst_n(rst_n), .vd(vd), .rdy(rdy), .busy(busy), .res(res), .cmp(cmp),
        .exp_res(exp_res), .exp_cmp(exp_cmp), .exp_lat(exp_lat),
        .err_cnt(err_cnt), .chk_cnt(chk_cnt)
    );

    // --------------------
    // Reference model
    // --------------------
    function automatic logic compare_decision(ialu_cmd_e cmd, ialu_word_t a, ialu_word_t b);
        case (cmd)
            cmd_lt:  return $signed(a) < $signed(b);
            cmd_ltu: return a < b;
            cmd_eq:  return a == b;
            cmd_ne:  return a != b;
            cmd_ge:  return $signed(a) >= $signed(b);
            default: return a >= b;                // geu
        endcase
    endfunction

    function automatic row_s build_row(ialu_cmd_e cmd, ialu_word_t a, ialu_word_t b);
        row_s                   r;
        logic [2*ialu_xlen-1:0] xa;
        logic [2*ialu_xlen-1:0] xb;
        logic [2*ialu_xlen-1:0] prod;
        ialu_word_t             ones;
        logic                   a_signed;
        logic                   b_signed;
        a_signed = (cmd == cmd_mul) || (cmd == cmd_mulh) || (cmd == cmd_mulhsu);
        b_signed = (cmd == cmd_mul) || (cmd == cmd_mulh);
        xa   = {{ialu_xlen{a_signed & a[ialu_xlen-1]}}, a};
        xb   = {{ialu_xlen{b_signed & b[ialu_xlen-1]}}, b};
        prod = xa * xb;                            // 64-bit product of extended operands
        ones = '1;
        r    = '{cmd: cmd, op1: a, op2: b, exp_res: '0, exp_cmp: 1'b0, lat: 1};
        case (cmd)
            cmd_add: r.exp_res = a + b;
            cmd_sub: r.exp_res = a - b;
            cmd_lt, cmd_ltu, cmd_eq, cmd_ne, cmd_ge, cmd_geu: begin
                r.exp_cmp = compare_decision(cmd, a, b);
                r.exp_res = ialu_word_t'(r.exp_cmp);
            end
            cmd_and: r.exp_res = a & b;
            cmd_or:  r.exp_res = a | b;
            cmd_xor: r.exp_res = a ^ b;
            cmd_sll: r.exp_res = a << b[4:0];
            cmd_srl: r.exp_res = a >> b[4:0];
            cmd_sra: r.exp_res = (a >> b[4:0]) | (a[ialu_xlen-1] ? ~(ones >> b[4:0]) : '0);
            cmd_mul: r.exp_res = prod[ialu_xlen-1:0];
            default: r.exp_res = prod[2*ialu_xlen-1:ialu_xlen];
        endcase
        if ((cmd >= cmd_mul) && (a != 0) && (b != 0)) begin
            r.lat = ialu_xlen / mul_step;
        end
        return r;
    endfunction

    task automatic fill_table();
        ialu_word_t corner [5];
        ialu_word_t a;
        ialu_word_t b;
        int         n;
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        n = 0;
        for (int k = 0; k < 18; k++) begin
            for (int x = 0; x < 5; x++) begin
                for (int y = 0; y < 5; y++) begin
                    tbl[n] = build_row(ialu_cmd_e'(k), corner[x], corner[y]);
                    n = n + 1;
                end
            end
        end
        tbl[n]     = build_row(cmd_sll, 32'h8000_0001, 32'd31);
        tbl[n + 1] = build_row(cmd_srl, 32'h8000_0001, 32'd31);
        tbl[n + 2] = build_row(cmd_sra, 32'h8000_0001, 32'd31);
        n = n + 3;
        while (n < n_rows) begin
            a = $urandom();
            b = $urandom();
            if ($urandom_range(7, 0) == 0) a = '0;   // Zero operands now and then
            if ($urandom_range(7, 0) == 0) b = '0;
            tbl[n] = build_row(ialu_cmd_e'($urandom_range(17, 0)), a, b);
            n = n + 1;
        end
    endtask

    // --------------------
    // Driver
    // --------------------
    task automatic apply_row(input int i);
        vd      <= 1'b1;
        req.cmd <= tbl[i].cmd;
        req.op1 <= tbl[i].op1;
        req.op2 <= tbl[i].op2;
        exp_res <= tbl[i].exp_res;
        exp_cmp <= tbl[i].exp_cmp;
        exp_lat <= tbl[i].lat;
        @(posedge clk);
        while (rdy !== 1'b1) @(posedge clk);      // Hold until completion edge
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing the table", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(rand_seed));
        rst_n   = 1'b0;
        vd      = 1'b0;
        req     = '0;
        exp_res = '0;
        exp_cmp = 1'b0;
        exp_lat = 1;
        fill_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);                 // vd low after reset
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
            if ((i % 7) == 3) begin
                vd <= 1'b0;                        // One idle cycle between operations
                @(posedge clk);
            end
        end
        vd <= 1'b0;
        repeat (3) @(posedge clk);
        $display("Summary: %0d of %0d results checked, %0d errors", chk_cnt, n_rows, err_cnt);
        if ((err_cnt == 0) && (chk_cnt == n_rows)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/ialu_pkg.sv
logic/ialu_adder_cmp.sv
logic/ialu_logic_shift.sv
logic/ialu_mul_iter.sv
logic/ialu_ctrl.sv
logic/ialu_top.sv
verif/ialu_checker.sv
verif/tb_ialu.sv

/* Bender.yml */
package:
  name: ialu

sources:
  - files:
      - logic/ialu_pkg.sv
      - logic/ialu_adder_cmp.sv
      - logic/ialu_logic_shift.sv
      - logic/ialu_mul_iter.sv
      - logic/ialu_ctrl.sv
      - logic/ialu_top.sv
  - target: test
    files:
      - verif/ialu_checker.sv
      - verif/tb_ialu.sv
